// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT_ACK
    } bus_state_e;

    ////////////////////////////////////////
    // opcode field
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    ////////////////////////////////////////
    // function field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    localparam reg_addr_t LINK_REG_NONE = 5'd0;  // writes nothing

endpackage

// ==== rtl/stage_if.sv ====
interface if_id_if import cpu_pkg::*; ();
    logic  valid;
    word_t instr;
    word_t pc_next;

    modport source (output valid, instr, pc_next);
    modport sink   (input  valid, instr, pc_next);
endinterface

interface id_ex_if import cpu_pkg::*; ();
    logic      valid;
    alu_op_e   alu_op;
    word_t     rs_val;
    word_t     rt_val;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     imm;
    logic      use_imm;
    logic      is_load;
    logic      is_store;
    logic      is_beq;
    logic      is_bne;
    logic      is_jump;
    word_t     jump_target;
    word_t     pc_next;
    reg_addr_t dest;

    modport source (output valid, alu_op, rs_val, rt_val, rs, rt, imm, use_imm,
                    is_load, is_store, is_beq, is_bne, is_jump, jump_target, pc_next, dest);
    modport sink   (input  valid, alu_op, rs_val, rt_val, rs, rt, imm, use_imm,
                    is_load, is_store, is_beq, is_bne, is_jump, jump_target, pc_next, dest);
endinterface

interface ex_mem_if import cpu_pkg::*; ();
    logic      valid;
    word_t     result;
    word_t     store_data;
    logic      is_load;
    logic      is_store;
    reg_addr_t dest;

    modport source (output valid, result, store_data, is_load, is_store, dest);
    modport sink   (input  valid, result, store_data, is_load, is_store, dest);
endinterface

interface mem_wb_if import cpu_pkg::*; ();
    logic      valid;
    word_t     data;
    reg_addr_t dest;

    modport source (output valid, data, dest);
    modport sink   (input  valid, data, dest);
endinterface

// ==== rtl/fetch_stage.sv ====
module fetch_stage import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    hold,
    input  logic    stall_load,
    input  logic    redirect,
    input  word_t   redirect_pc,
    input  word_t   imem_data,
    output word_t   imem_addr,
    if_id_if.source if_id
);

    word_t pc;
    word_t pc_plus4;
    logic  advance;

    assign pc_plus4  = pc + 32'd4;
    assign imem_addr = pc;
    assign advance   = !hold && !redirect && !stall_load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc          <= RESET_PC;
            if_id.valid <= 1'b0;
        end else if (!hold) begin
            if (redirect) begin
                pc          <= redirect_pc;
                if_id.valid <= 1'b0;      // squash the word just fetched
            end else if (!stall_load) begin
                pc          <= pc_plus4;
                if_id.valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if_id.instr   <= imem_data;
            if_id.pc_next <= pc_plus4;
        end
    end

endmodule

// ==== rtl/decode_stage.sv ====
module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      hold,
    input  logic      redirect,
    if_id_if.sink     if_id,
    input  word_t     rs_val,
    input  word_t     rt_val,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output logic      stall_load,
    id_ex_if.source   id_ex
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    reg_addr_t   rd;
    word_t       simm;
    word_t       zimm;
    alu_op_e     alu_op;
    word_t       imm;
    logic        use_imm;
    logic        is_load;
    logic        is_store;
    logic        is_beq;
    logic        is_bne;
    logic        is_jump;
    logic        reads_rt;
    reg_addr_t   dest;

    assign opcode  = if_id.instr[31:26];
    assign rs_addr = if_id.instr[25:21];
    assign rt_addr = if_id.instr[20:16];
    assign rd      = if_id.instr[15:11];
    assign shamt   = if_id.instr[10:6];
    assign funct   = if_id.instr[5:0];
    assign imm16   = if_id.instr[15:0];
    assign simm    = {{16{imm16[15]}}, imm16};
    assign zimm    = {16'b0, imm16};

    always_comb begin
        alu_op   = ALU_ADD;
        imm      = simm;
        use_imm  = 1'b1;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        is_jump  = 1'b0;
        reads_rt = 1'b0;
        dest     = LINK_REG_NONE;
        case (opcode)
            OP_SPECIAL: begin
                use_imm  = 1'b0;
                reads_rt = 1'b1;
                imm      = {27'b0, shamt};  // shift amount
                dest     = rd;
                case (funct)
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLT:          alu_op = ALU_SLT;
                    FN_SLTU:         alu_op = ALU_SLTU;
                    FN_SLL:          alu_op = ALU_SLL;
                    FN_SRL:          alu_op = ALU_SRL;
                    FN_SRA:          alu_op = ALU_SRA;
                    default:         dest   = LINK_REG_NONE;  // no-op
                endcase
            end
            OP_ADDI, OP_ADDIU: dest = rt_addr;
            OP_SLTI: begin
                alu_op = ALU_SLT;
                dest   = rt_addr;
            end
            OP_ANDI: begin
                alu_op = ALU_AND;
                imm    = zimm;
                dest   = rt_addr;
            end
            OP_ORI: begin
                alu_op = ALU_OR;
                imm    = zimm;
                dest   = rt_addr;
            end
            OP_XORI: begin
                alu_op = ALU_XOR;
                imm    = zimm;
                dest   = rt_addr;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                imm    = {imm16, 16'b0};
                dest   = rt_addr;
            end
            OP_BEQ: begin
                is_beq   = 1'b1;
                reads_rt = 1'b1;
            end
            OP_BNE: begin
                is_bne   = 1'b1;
                reads_rt = 1'b1;
            end
            OP_J:    is_jump = 1'b1;
            OP_LW: begin
                is_load = 1'b1;
                dest    = rt_addr;
            end
            OP_SW: begin
                is_store = 1'b1;
                reads_rt = 1'b1;
            end
            default: ;
        endcase
    end

    // load in execute feeding the word in decode
    assign stall_load = if_id.valid && id_ex.valid && id_ex.is_load
                        && (id_ex.dest != LINK_REG_NONE)
                        && (((id_ex.dest == rs_addr) && !is_jump)
                            || ((id_ex.dest == rt_addr) && reads_rt));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else if (!hold) begin
            id_ex.valid <= if_id.valid && !redirect && !stall_load;  // bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            id_ex.alu_op      <= alu_op;
            id_ex.rs_val      <= rs_val;
            id_ex.rt_val      <= rt_val;
            id_ex.rs          <= rs_addr;
            id_ex.rt          <= rt_addr;
            id_ex.imm         <= imm;
            id_ex.use_imm     <= use_imm;
            id_ex.is_load     <= is_load;
            id_ex.is_store    <= is_store;
            id_ex.is_beq      <= is_beq;
            id_ex.is_bne      <= is_bne;
            id_ex.is_jump     <= is_jump;
            id_ex.jump_target <= {if_id.pc_next[31:28], if_id.instr[25:0], 2'b00};
            id_ex.pc_next     <= if_id.pc_next;
            id_ex.dest        <= dest;
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    mem_wb_if.sink    mem_wb,
    output word_t     rs_val,
    output word_t     rt_val
);

    word_t regs [0:31];
    logic  wr_en;

    assign wr_en = mem_wb.valid && (mem_wb.dest != LINK_REG_NONE);  // r0 never written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[mem_wb.dest] <= mem_wb.data;
        end
    end

    // write-through
    assign rs_val = (wr_en && (mem_wb.dest == rs_addr)) ? mem_wb.data : regs[rs_addr];
    assign rt_val = (wr_en && (mem_wb.dest == rt_addr)) ? mem_wb.data : regs[rt_addr];

endmodule

// ==== rtl/execute_stage.sv ====
module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    id_ex_if.sink    id_ex,
    mem_wb_if.sink   mem_wb,
    ex_mem_if.source ex_mem,
    output logic     redirect,
    output word_t    redirect_pc
);

    logic  ex_fwd_ok;
    logic  wb_fwd_ok;
    word_t op_a;
    word_t rt_fwd;
    word_t op_b;
    word_t result;
    word_t branch_target;
    logic  operands_equal;
    logic  taken;

    ////////////////////////////////////////
    // forwarding
    assign ex_fwd_ok = ex_mem.valid && !ex_mem.is_load && (ex_mem.dest != LINK_REG_NONE);
    assign wb_fwd_ok = mem_wb.valid && (mem_wb.dest != LINK_REG_NONE);

    always_comb begin
        if (ex_fwd_ok && (ex_mem.dest == id_ex.rs))
            op_a = ex_mem.result;
        else if (wb_fwd_ok && (mem_wb.dest == id_ex.rs))
            op_a = mem_wb.data;
        else
            op_a = id_ex.rs_val;

        if (ex_fwd_ok && (ex_mem.dest == id_ex.rt))
            rt_fwd = ex_mem.result;
        else if (wb_fwd_ok && (mem_wb.dest == id_ex.rt))
            rt_fwd = mem_wb.data;
        else
            rt_fwd = id_ex.rt_val;
    end

    assign op_b = id_ex.use_imm ? id_ex.imm : rt_fwd;

    ////////////////////////////////////////
    // alu
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_NOR:  result = ~(op_a | op_b);
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_SLL:  result = op_b << id_ex.imm[4:0];   // shifts take rt
            ALU_SRL:  result = op_b >> id_ex.imm[4:0];
            ALU_SRA:  result = $signed(op_b) >>> id_ex.imm[4:0];
            ALU_LUI:  result = op_b;
            default:  result = op_a + op_b;
        endcase
    end

    ////////////////////////////////////////
    // branch and jump
    assign operands_equal = (op_a == rt_fwd);
    assign taken          = id_ex.is_jump
                            || (id_ex.is_beq && operands_equal)
                            || (id_ex.is_bne && !operands_equal);
    assign branch_target  = id_ex.pc_next + {id_ex.imm[29:0], 2'b00};
    assign redirect       = id_ex.valid && taken;
    assign redirect_pc    = id_ex.is_jump ? id_ex.jump_target : branch_target;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else if (!hold) begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_mem.result     <= result;
            ex_mem.store_data <= rt_fwd;
            ex_mem.is_load    <= id_ex.is_load;
            ex_mem.is_store   <= id_ex.is_store;
            ex_mem.dest       <= id_ex.dest;
        end
    end

endmodule

// ==== rtl/mem_stage.sv ====
module mem_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    ex_mem_if.sink   ex_mem,
    input  word_t    wb_dat_r,
    input  logic     wb_ack,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output word_t    wb_adr,
    output word_t    wb_dat_w,
    output logic     hold,
    mem_wb_if.source mem_wb
);

    bus_state_e state;
    logic       access;
    logic       done;
    logic       gap_q;   // forces cyc low for a cycle after ack

    assign access   = ex_mem.valid && (ex_mem.is_load || ex_mem.is_store);
    assign wb_cyc   = (state == BUS_WAIT_ACK) || (access && !gap_q);
    assign wb_stb   = wb_cyc;
    assign wb_we    = ex_mem.is_store;
    assign wb_adr   = ex_mem.result;
    assign wb_dat_w = ex_mem.store_data;
    assign done     = wb_cyc && wb_ack;
    assign hold     = access && !done;   // stalls the whole core

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= BUS_IDLE;
            gap_q <= 1'b0;
        end else begin
            gap_q <= done;
            case (state)
                BUS_IDLE:     if (wb_cyc && !wb_ack) state <= BUS_WAIT_ACK;
                BUS_WAIT_ACK: if (wb_ack) state <= BUS_IDLE;
                default:      state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else if (!hold) begin
            mem_wb.valid <= ex_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            mem_wb.data <= ex_mem.is_load ? wb_dat_r : ex_mem.result;  // read data on ack edge
            mem_wb.dest <= ex_mem.is_store ? LINK_REG_NONE : ex_mem.dest;
        end
    end

endmodule

// ==== rtl/pipe_cpu.sv ====
module pipe_cpu import cpu_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst,
    output word_t imem_addr,
    input  word_t imem_data,
    output logic  wb_cyc,
    output logic  wb_stb,
    output logic  wb_we,
    output word_t wb_adr,
    output word_t wb_dat_w,
    input  word_t wb_dat_r,
    input  logic  wb_ack
);

    logic      hold;
    logic      stall_load;
    logic      redirect;
    word_t     redirect_pc;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_val;
    word_t     rt_val;

    if_id_if  if_id  ();
    id_ex_if  id_ex  ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .stall_load  (stall_load),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .if_id       (if_id)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .hold       (hold),
        .redirect   (redirect),
        .if_id      (if_id),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .stall_load (stall_load),
        .id_ex      (id_ex)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .mem_wb  (mem_wb),
        .rs_val  (rs_val),
        .rt_val  (rt_val)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .id_ex       (id_ex),
        .mem_wb      (mem_wb),
        .ex_mem      (ex_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    mem_stage u_mem (
        .clk      (clk),
        .rst      (rst),
        .ex_mem   (ex_mem),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .hold     (hold),
        .mem_wb   (mem_wb)
    );

endmodule

// ==== testbench/pipe_cpu_props.sv ====
module pipe_cpu_props import cpu_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  wb_cyc,
    input logic  wb_stb,
    input logic  wb_we,
    input word_t wb_adr,
    input word_t wb_dat_w,
    input logic  wb_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // request held until the slave answers
    hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)
                                 && $stable(wb_we) && $stable(wb_dat_w)))
        else $error("bus request changed before wb_ack");

    cyc_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !wb_cyc)
        else $error("wb_cyc high in the cycle after reset");

endmodule

bind pipe_cpu pipe_cpu_props u_props (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack)
);

// ==== testbench/tb_pipe_cpu.sv ====
module tb_pipe_cpu import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t RESET_PC = 32'h0000_0000;

    logic  clk;
    logic  rst;
    word_t imem_addr;
    word_t imem_data;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    word_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic  wb_ack;

    word_t rom [0:63];
    int    rom_words;
    word_t dmem [0:255];
    word_t exp_adr [$];
    word_t exp_dat [$];
    word_t seed;
    int    stores_seen;
    int    errors;
    logic  slave_busy;
    logic  first_access;
    int    wait_left;

    pipe_cpu #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // reporting
    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_fail(input string what);
        $display("%s", what);
        errors++;
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
            stop_run();
        end
    endtask

    function automatic word_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    ////////////////////////////////////////
    // instruction rom, jump-to-self outside the program
    always_comb begin
        if (((imem_addr - RESET_PC) >> 2) < rom_words)
            imem_data = rom[(imem_addr - RESET_PC) >> 2];
        else
            imem_data = {OP_J, imem_addr[27:2]};
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        word_t       a;
        word_t       d;
        fd = $fopen("testbench/program_vectors.txt", "r");
        if (fd == 0)
            report_fail("cannot open testbench/program_vectors.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h", kind, a, d);
                if (kind == "I") begin
                    rom[(a - RESET_PC) >> 2] = d;
                    rom_words = ((a - RESET_PC) >> 2) + 1;
                end else if (kind == "D") begin
                    dmem[a[9:2]] = d;
                end else if (kind == "S") begin
                    exp_adr.push_back(a);
                    exp_dat.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // wishbone slave, driven on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_ack) begin
                wb_ack     = 1'b0;
                slave_busy = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (first_access && !wb_we)
                    report_fail("bus cycle opened before the first store");
                if (wb_adr[31:10] != 0)
                    report_fail("bus address outside the data memory");
                if (!slave_busy) begin
                    slave_busy = 1'b1;
                    wait_left  = int'(lcg_next() >> 16) % 4;
                end
                if (wait_left == 0) begin
                    first_access = 1'b0;
                    wb_ack       = 1'b1;
                    if (wb_we) begin
                        if (exp_adr.size() == 0) begin
                            report_fail("store arrived after the expected list ended");
                        end else begin
                            check_addr("wb_adr", exp_adr.pop_front(), wb_adr);
                            check_word("wb_dat_w", exp_dat.pop_front(), wb_dat_w);
                            dmem[wb_adr[9:2]] = wb_dat_w;
                            stores_seen++;
                        end
                    end else begin
                        wb_dat_r = dmem[wb_adr[9:2]];
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    initial begin
        int total;
        int cycles;
        clk          = 1'b0;
        rst          = 1'b1;
        wb_dat_r     = '0;
        wb_ack       = 1'b0;
        seed         = 32'h2dad_609f;
        stores_seen  = 0;
        errors       = 0;
        slave_busy   = 1'b0;
        first_access = 1'b1;
        wait_left    = 0;
        rom_words    = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd000_0000 ^ (i << 2);  // whole address in the fill
        end
        load_vectors();
        total = exp_adr.size();

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_addr("imem_addr", RESET_PC, imem_addr);

        for (int i = 0; i < total; i++) begin
            cycles = 0;
            while (stores_seen <= i && cycles < 200) begin
                @(posedge clk);
                cycles++;
            end
            if (stores_seen <= i)
                report_fail("no store arrived within 200 cycles");
        end

        repeat (20) @(posedge clk);  // stray stores show up in the slave
        if (errors == 0 && stores_seen == total) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== testbench/program_vectors.txt ====
# I <byte addr> <instruction>, D <byte addr> <initial data>
# S <store addr> <store data> in expected order
I 00000000 24010100
I 00000004 20020005
I 00000008 2003FFFD
I 0000000C 00432020
I 00000010 AC240000
I 00000014 00432822
I 00000018 AC250004
I 0000001C 00433024
I 00000020 AC260008
I 00000024 00433825
I 00000028 AC27000C
I 0000002C 00434026
I 00000030 AC280010
I 00000034 00434827
I 00000038 AC290014
I 0000003C 0062502A
I 00000040 0062582B
I 00000044 AC2A0018
I 00000048 AC2B001C
I 0000004C 00036100
I 00000050 00036F02
I 00000054 00037043
I 00000058 AC2C0020
I 0000005C AC2D0024
I 00000060 AC2E0028
I 00000064 306FF0F0
I 00000068 34508000
I 0000006C 3A1100FF
I 00000070 2872FFFE
I 00000074 3C131234
I 00000078 AC2F002C
I 0000007C AC300030
I 00000080 AC310034
I 00000084 AC320038
I 00000088 AC33003C
I 0000008C 8C340080
I 00000090 26950001
I 00000094 AC350040
I 00000098 10420002
I 0000009C AC220044
I 000000A0 AC230048
I 000000A4 14420002
I 000000A8 AC22004C
I 000000AC 14430002
I 000000B0 AC220050
I 000000B4 AC220054
I 000000B8 10430002
I 000000BC 08000032
I 000000C0 AC220058
I 000000C4 AC22005C
I 000000C8 AC230060
I 000000CC 08000033
D 00000180 CAFE0001
S 00000100 00000002
S 00000104 00000008
S 00000108 00000005
S 0000010C FFFFFFFD
S 00000110 FFFFFFF8
S 00000114 00000002
S 00000118 00000001
S 0000011C 00000000
S 00000120 FFFFFFD0
S 00000124 0000000F
S 00000128 FFFFFFFE
S 0000012C 0000F0F0
S 00000130 00008005
S 00000134 000080FA
S 00000138 00000001
S 0000013C 12340000
S 00000140 CAFE0002
S 0000014C 00000005
S 00000160 FFFFFFFD

// ==== pipe_cpu.f ====
rtl/cpu_pkg.sv
rtl/stage_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/pipe_cpu.sv
testbench/pipe_cpu_props.sv
testbench/tb_pipe_cpu.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module pipe_cpu rtl/cpu_pkg.sv rtl/stage_if.sv \
		rtl/fetch_stage.sv rtl/decode_stage.sv rtl/reg_file.sv rtl/execute_stage.sv \
		rtl/mem_stage.sv rtl/pipe_cpu.sv
	verilator --lint-only --timing --assert --top-module tb_pipe_cpu -f pipe_cpu.f

sim:
	verilator --binary --timing --assert --top-module tb_pipe_cpu -f pipe_cpu.f -Mdir obj_dir
	./obj_dir/Vtb_pipe_cpu > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
